// ==== common/exec_pkg.sv ====
package exec_pkg;

	// Datapath width, fixed by the instruction set
	localparam int XLEN = 32;

	// Opcode encoding of the execute stage
	typedef enum logic [4:0] {
		OP_AND   = 5'b00000,
		OP_OR    = 5'b00001,
		OP_XOR   = 5'b00010,
		OP_ADDU  = 5'b00011,
		OP_SUBU  = 5'b00100,
		OP_SLTU  = 5'b00101,
		OP_SLT   = 5'b00110,
		OP_MULTU = 5'b00111,
		OP_MULT  = 5'b01000,
		OP_SLL   = 5'b01001,        // Shift by shamt
		OP_SLLV  = 5'b01010,        // Shift by b[4:0]
		OP_SRA   = 5'b01011,
		OP_SRL   = 5'b01100,
		OP_SRAV  = 5'b01101,
		OP_SRLV  = 5'b01110,
		OP_DIV   = 5'b01111,
		OP_DIVU  = 5'b10000,
		OP_MFHI  = 5'b10001,
		OP_MFLO  = 5'b10010,
		OP_BLTZ  = 5'b10011,
		OP_BGTZ  = 5'b10100,
		OP_BEQZ  = 5'b10101,
		OP_BNEZ  = 5'b10110,
		OP_LUI   = 5'b10111,
		OP_JR    = 5'b11000
	} alu_op_e;

	// Which unit handles an operation
	typedef enum logic [1:0] {
		CLS_CORE      = 2'd0,       // Result from the core unit
		CLS_MULDIV_WR = 2'd1,       // Updates HI/LO, no output
		CLS_MULDIV_RD = 2'd2        // Reads HI or LO
	} op_class_e;

	// One operation as it enters the stage
	typedef struct packed {
		alu_op_e         op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [4:0]      shamt;
	} exec_req_t;

	// Issue register contents
	typedef struct packed {
		logic      valid;
		exec_req_t req;
		op_class_e cls;
	} issue_t;

	// Result of one execute unit
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] result;
	} exec_res_t;

endpackage

// ==== alu/alu_issue.sv ====
`timescale 1ns/1ps

module alu_issue (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  exec_pkg::exec_req_t in_req,
	output exec_pkg::issue_t    iss
);
	import exec_pkg::*;

	logic      valid_q;
	exec_req_t req_q;
	op_class_e cls_d;
	op_class_e cls_q;

	// Decode the unit once here, later stages steer on the class
	always_comb begin
		case (in_req.op)
			OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: cls_d = CLS_MULDIV_WR;
			OP_MFHI, OP_MFLO:                   cls_d = CLS_MULDIV_RD;
			default:                            cls_d = CLS_CORE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid;    // One slot per cycle, no stall
		end
	end

	// Operands only load on a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			req_q <= in_req;
			cls_q <= cls_d;
		end
	end

	assign iss = '{
		valid: valid_q,
		req:   req_q,
		cls:   cls_q
	};

endmodule

// ==== alu/alu_core.sv ====
`timescale 1ns/1ps

module alu_core (
	input  exec_pkg::issue_t    iss,
	output exec_pkg::exec_res_t core_res
);
	import exec_pkg::*;

	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic [4:0]      sh;        // Effective shift amount
	logic [XLEN-1:0] y;
	logic            a_zero;

	assign opa    = iss.req.a;
	assign opb    = iss.req.b;
	assign a_zero = (opa == '0);

	// Variable shifts take the amount from b, the rest from shamt
	always_comb begin
		case (iss.req.op)
			OP_SLLV, OP_SRLV, OP_SRAV: sh = opb[4:0];
			default:                   sh = iss.req.shamt;
		endcase
	end

	always_comb begin
		case (iss.req.op)
			OP_AND: begin
				y = opa & opb;
			end
			OP_OR: begin
				y = opa | opb;
			end
			OP_XOR: begin
				y = opa ^ opb;
			end
			OP_ADDU: begin
				y = opa + opb;      // No overflow trap
			end
			OP_SUBU: begin
				y = opa - opb;
			end
			OP_SLTU: begin
				y = {31'b0, opa < opb};
			end
			OP_SLT: begin
				y = {31'b0, $signed(opa) < $signed(opb)};
			end
			OP_SLL, OP_SLLV: begin
				y = opa << sh;
			end
			OP_SRL, OP_SRLV: begin
				y = opa >> sh;
			end
			OP_SRA, OP_SRAV: begin
				y = $unsigned($signed(opa) >>> sh);    // Sign fill
			end
			// Branch conditions give 1 when taken
			OP_BLTZ: begin
				y = {31'b0, opa[31]};
			end
			OP_BGTZ: begin
				y = {31'b0, ~opa[31] & ~a_zero};
			end
			OP_BEQZ: begin
				y = {31'b0, a_zero};
			end
			OP_BNEZ: begin
				y = {31'b0, ~a_zero};
			end
			OP_LUI: begin
				y = opb << 16;
			end
			OP_JR: begin
				y = opa;            // Target passes straight through
			end
			default: begin
				y = '0;             // Muldiv ops, not ours
			end
		endcase
	end

	assign core_res = '{
		valid:  iss.valid && (iss.cls == CLS_CORE),
		result: y
	};

endmodule

// ==== alu/alu_muldiv.sv ====
`timescale 1ns/1ps

module alu_muldiv (
	input  logic                clk,
	input  logic                rst_n,
	input  exec_pkg::issue_t    iss,
	output exec_pkg::exec_res_t md_res
);
	import exec_pkg::*;

	logic [XLEN-1:0]   hi_q;
	logic [XLEN-1:0]   lo_q;
	logic              is_signed;
	logic              is_mul;
	logic              neg_a;
	logic              neg_b;
	logic [XLEN-1:0]   mag_a;
	logic [XLEN-1:0]   mag_b;
	logic [2*XLEN-1:0] mag_prod;
	logic [2*XLEN-1:0] prod;
	logic [XLEN-1:0]   mag_quo;
	logic [XLEN-1:0]   mag_rem;
	logic [XLEN-1:0]   quo;
	logic [XLEN-1:0]   rem;
	logic              div_zero;

	assign is_signed = (iss.req.op == OP_MULT) || (iss.req.op == OP_DIV);
	assign is_mul    = (iss.req.op == OP_MULT) || (iss.req.op == OP_MULTU);

	// Signed ops run on magnitudes so one multiplier and divider serve both
	assign neg_a = is_signed & iss.req.a[31];
	assign neg_b = is_signed & iss.req.b[31];
	assign mag_a = neg_a ? -iss.req.a : iss.req.a;
	assign mag_b = neg_b ? -iss.req.b : iss.req.b;

	assign mag_prod = {32'b0, mag_a} * {32'b0, mag_b};
	assign prod     = (neg_a ^ neg_b) ? -mag_prod : mag_prod;

	assign div_zero = (iss.req.b == '0);
	assign mag_quo  = div_zero ? '0 : mag_a / mag_b;
	assign mag_rem  = div_zero ? '0 : mag_a % mag_b;

	always_comb begin
		if (div_zero) begin
			quo = '1;               // All ones on divide by zero
			rem = iss.req.a;
		end else begin
			quo = (neg_a ^ neg_b) ? -mag_quo : mag_quo;    // Truncates toward zero
			rem = neg_a ? -mag_rem : mag_rem;               // Dividend sign
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (iss.valid && (iss.cls == CLS_MULDIV_WR)) begin
			if (is_mul) begin
				hi_q <= prod[63:32];
				lo_q <= prod[31:0];
			end else begin
				hi_q <= rem;
				lo_q <= quo;
			end
		end
	end

	// Reads see HI/LO written at the previous edge
	assign md_res = '{
		valid:  iss.valid && (iss.cls == CLS_MULDIV_RD),
		result: (iss.req.op == OP_MFHI) ? hi_q : lo_q
	};

endmodule

// ==== design/exec_writeback.sv ====
`timescale 1ns/1ps

module exec_writeback (
	input  logic                clk,
	input  logic                rst_n,
	input  exec_pkg::exec_res_t core_res,
	input  exec_pkg::exec_res_t md_res,
	output logic                out_valid,
	output logic [31:0]         result,
	output logic                zero
);
	import exec_pkg::*;

	logic            valid_d;
	logic [XLEN-1:0] sel_result;

	// The two sources are never valid together
	assign valid_d    = core_res.valid | md_res.valid;
	assign sel_result = core_res.valid ? core_res.result : md_res.result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= valid_d;
		end
	end

	// Result and flag hold between strobes
	always_ff @(posedge clk) begin
		if (valid_d) begin
			result <= sel_result;
			zero   <= (sel_result == '0);
		end
	end

endmodule

// ==== design/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  exec_pkg::exec_req_t in_req,
	output logic                out_valid,
	output logic [31:0]         result,
	output logic                zero
);
	import exec_pkg::*;

	issue_t    iss;         // Issue stage register
	exec_res_t core_res;    // Core unit result
	exec_res_t md_res;      // HI/LO read result

	alu_issue alu_issue_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_req   (in_req),
		.iss      (iss)
	);

	alu_core alu_core_i (
		.iss      (iss),
		.core_res (core_res)
	);

	alu_muldiv alu_muldiv_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.iss    (iss),
		.md_res (md_res)
	);

	exec_writeback exec_writeback_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.core_res  (core_res),
		.md_res    (md_res),
		.out_valid (out_valid),
		.result    (result),
		.zero      (zero)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;         // 40 ns period
		end
	end

	// Reset spans ten rising edges and is released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== test/exec_chk.sv ====
`timescale 1ns/1ps

module exec_chk (
	input logic                clk,
	input logic                rst_n,
	input logic                in_valid,
	input exec_pkg::exec_req_t in_req,
	input logic                out_valid,
	input logic [31:0]         result,
	input logic                zero
);
	import exec_pkg::*;

	logic produces;             // Sampled op that owes an output
	int   fail_count = 0;

	assign produces = in_valid && !(in_req.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU});

	out_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
	) else begin
		$error("out_valid is unknown after reset");
		fail_count++;
	end

	// Output strobe lands two edges after the input was sampled
	out_valid_latency: assert property (
		@(posedge clk) disable iff (!rst_n) out_valid == $past(produces, 2)
	) else begin
		$error("out_valid does not follow the sampled input strobe");
		fail_count++;
	end

	zero_matches_result: assert property (
		@(posedge clk) disable iff (!rst_n) out_valid |-> (zero == (result == 32'h0))
	) else begin
		$error("zero flag disagrees with result");
		fail_count++;
	end

endmodule

// ==== test/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;
	import exec_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	exec_req_t   in_req;
	logic        out_valid;
	logic [31:0] result;
	logic        zero;

	logic [31:0] rng_state;
	logic [31:0] hi_model;
	logic [31:0] lo_model;
	logic [31:0] exp_q[$];      // Results in flight, oldest first
	int          checks;
	int          errors;

	tb_clock tb_clock_i (.*);

	exec_top exec_top_i (.*);

	bind exec_top exec_chk exec_chk_i (.*);

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [31:0] expected_result(exec_req_t r);
		logic [4:0] n;
		n = (r.op inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? r.b[4:0] : r.shamt;
		case (r.op)
			OP_AND:          return r.a & r.b;
			OP_OR:           return r.a | r.b;
			OP_XOR:          return r.a ^ r.b;
			OP_ADDU:         return r.a + r.b;
			OP_SUBU:         return r.a - r.b;
			OP_SLTU:         return {31'b0, r.a < r.b};
			OP_SLT:          return {31'b0, (r.a ^ 32'h80000000) < (r.b ^ 32'h80000000)};
			OP_SLL, OP_SLLV: return r.a << n;
			OP_SRL, OP_SRLV: return r.a >> n;
			OP_SRA, OP_SRAV: return (r.a >> n) | (r.a[31] ? ~(32'hffffffff >> n) : 32'h0);
			OP_BLTZ:         return {31'b0, r.a[31]};
			OP_BGTZ:         return {31'b0, !r.a[31] && r.a != 32'h0};
			OP_BEQZ:         return {31'b0, r.a == 32'h0};
			OP_BNEZ:         return {31'b0, r.a != 32'h0};
			OP_LUI:          return {r.b[15:0], 16'h0};
			OP_JR:           return r.a;
			OP_MFHI:         return hi_model;
			OP_MFLO:         return lo_model;
			default:         return 32'h0;
		endcase
	endfunction

	// HI in the upper half, LO in the lower half
	task automatic update_hilo(exec_req_t r);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        p;
		sa = {{32{r.a[31]}}, r.a};
		sb = {{32{r.b[31]}}, r.b};
		if (r.op == OP_MULT) begin
			p = sa * sb;
		end else if (r.op == OP_MULTU) begin
			p = {32'h0, r.a} * {32'h0, r.b};
		end else if (r.b == 32'h0) begin
			p = {r.a, 32'hffffffff};
		end else if (r.op == OP_DIV) begin
			p = {32'(sa % sb), 32'(sa / sb)};   // Truncating divide
		end else begin
			p = {r.a % r.b, r.a / r.b};
		end
		hi_model = p[63:32];
		lo_model = p[31:0];
	endtask

	task automatic check_output();
		logic [31:0] want;
		if (out_valid === 1'b1 && exp_q.size() == 0) begin
			errors++;
			$display("Output strobe at %0t with no operation pending", $time);
		end else if (out_valid === 1'b1) begin
			want = exp_q.pop_front();
			checks++;
			if (result !== want) begin
				errors++;
				$display("error at %0t: result expected %h, actual %h", $time, want, result);
			end
			if (zero !== (want == 32'h0)) begin
				errors++;
				$display("error at %0t: zero expected %b, actual %b", $time, want == 32'h0, zero);
			end
		end
	endtask

	// Outputs are sampled before the next operation is driven
	task automatic send(alu_op_e op, logic [31:0] a, logic [31:0] b, logic [4:0] shamt);
		exec_req_t r;
		r = '{op: op, a: a, b: b, shamt: shamt};
		@(negedge clk);
		check_output();
		in_valid = 1'b1;
		in_req   = r;
		if (op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
			update_hilo(r);
		end else begin
			exp_q.push_back(expected_result(r));
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		check_output();
		in_valid = 1'b0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(negedge clk);
			check_output();
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("Timed out at %0t with %0d results missing", $time, exp_q.size());
			exp_q.delete();
		end
	endtask

	task automatic run_op(alu_op_e op, logic [31:0] a, logic [31:0] b, logic [4:0] shamt);
		send(op, a, b, shamt);
		drain();
	endtask

	// Readback right behind the write
	task automatic check_hilo(alu_op_e op, logic [31:0] a, logic [31:0] b);
		send(op, a, b, 5'd0);
		send(OP_MFHI, 32'h0, 32'h0, 5'd0);
		send(OP_MFLO, 32'h0, 32'h0, 5'd0);
		drain();
	endtask

	task automatic test_core_ops();
		logic [31:0] vals[7];
		alu_op_e     ops[13];
		vals = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h0, 32'h0, 32'h0};
		ops  = '{OP_AND, OP_OR, OP_XOR, OP_ADDU, OP_SUBU, OP_SLTU, OP_SLT, OP_LUI, OP_JR,
			OP_BLTZ, OP_BGTZ, OP_BEQZ, OP_BNEZ};
		for (int i = 4; i < 7; i++) begin
			vals[i] = xorshift32();
		end
		foreach (ops[k]) begin
			foreach (vals[i]) begin
				foreach (vals[j]) begin
					run_op(ops[k], vals[i], vals[j], 5'd0);
				end
			end
		end
	endtask

	task automatic test_shifts();
		logic [31:0] vals[4];
		logic [4:0]  amts[6];
		logic [31:0] r;
		vals = '{32'h80000001, 32'h7fffffff, 32'hf0f0f0f0, 32'h0};
		amts = '{5'd0, 5'd1, 5'd31, 5'd0, 5'd0, 5'd0};
		vals[3] = xorshift32();
		for (int k = 3; k < 6; k++) begin
			r = xorshift32();
			amts[k] = r[4:0];
		end
		foreach (vals[i]) begin
			foreach (amts[k]) begin
				r = xorshift32();
				run_op(OP_SLL, vals[i], r, amts[k]);
				run_op(OP_SRL, vals[i], r, amts[k]);
				run_op(OP_SRA, vals[i], r, amts[k]);
				run_op(OP_SLLV, vals[i], {r[31:5], amts[k]}, ~amts[k]);   // shamt ignored
				run_op(OP_SRLV, vals[i], {r[31:5], amts[k]}, ~amts[k]);
				run_op(OP_SRAV, vals[i], {r[31:5], amts[k]}, ~amts[k]);
			end
		end
	endtask

	task automatic test_muldiv();
		logic [31:0] x[6];
		logic [31:0] y[6];
		x = '{32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h7, 32'hfffffff9, 32'h0};
		y = '{32'h2, 32'hfffffffe, 32'h0, 32'hffffffff, 32'h3, 32'h0};
		x[5] = xorshift32();
		y[5] = xorshift32();
		foreach (x[i]) begin
			foreach (y[j]) begin
				check_hilo(OP_MULT, x[i], y[j]);
				check_hilo(OP_MULTU, x[i], y[j]);
				check_hilo(OP_DIV, x[i], y[j]);
				check_hilo(OP_DIVU, x[i], y[j]);
			end
		end
	endtask

	// Random opcodes every cycle, muldiv writes included
	task automatic test_stream();
		logic [31:0] r;
		for (int n = 0; n < 60; n++) begin
			r = xorshift32();
			send(alu_op_e'(r[4:0] % 5'd25), xorshift32(), xorshift32(), r[9:5]);
		end
		drain();
	endtask

	initial begin
		int waited;
		in_valid  = 1'b0;
		in_req    = '0;
		rng_state = 32'h2ed0bfd7;
		hi_model  = 32'h0;
		lo_model  = 32'h0;
		checks    = 0;
		errors    = 0;
		waited    = 0;
		@(negedge clk);
		while (!rst_n && waited < 40) begin
			@(negedge clk);
			waited++;
		end
		if (!rst_n) begin
			errors++;
			$display("Reset was never released");
		end
		test_core_ops();
		test_shifts();
		test_muldiv();
		test_stream();
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check_output();     // Catch a stray strobe
		end
		errors += exec_top_i.exec_chk_i.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== build.f ====
common/exec_pkg.sv
alu/alu_issue.sv
alu/alu_core.sv
alu/alu_muldiv.sv
design/exec_writeback.sv
design/exec_top.sv
test/tb_clock.sv
test/exec_chk.sv
test/exec_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exec_tb
FILELIST  = build.f
SIMFLAGS  = +verilator+error+limit+1000
PASS_MSG  = No errors

OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
